// File: all.f
design/dpll_lock_pkg.sv
design/dpll_lock_if.sv
design/error_sample.sv
design/cycle_correction.sv
design/lock_fsm.sv
design/code_accum.sv
design/dpll_lock_ctrl.sv
sim/tb_clock_gen.sv
sim/lock_checker.sv
sim/dpll_lock_tb.sv

// File: design/code_accum.sv
`timescale 1ns/10ps

module code_accum import dpll_lock_pkg::*; (
   input  logic      dco_change_edge,
   input  logic      reset2,
   corr_if.accum     corr,
   code_if.accum     code,
   input  gain_t     gain,
   input  cyc_t      divider,
   input  code_t     init_code,
   input  recip_t    freq_scale,
   input  recip_t    phase_scale,
   output out_code_t dco_code,
   output out_code_t locked_code
);

   logic [14:0]        gn_full;     // 6.2 * 7.0
   gainn_t             gain_n;
   recip_t             sel_scale;
   logic signed [14:0] corr_diff;
   logic signed [27:0] corr_prod;
   logic signed [27:0] corr_sum;
   code_t              base;
   logic signed [25:0] code_prod;
   logic signed [26:0] code_sum;
   code_t              code_next;
   code_t              code_reg;
   code_t              lock_reg;

   assign gn_full = gain * divider;
   assign gain_n = code.gain_en ? $signed(gn_full[13:2]) : '0;   // drop gain fraction

   ////////////////////////////////////////////////////////////////////////////
   // error correction

   always_comb begin
      case (corr.scale_sel)
         SCALE_FREQ:  sel_scale = freq_scale;
         SCALE_PHASE: sel_scale = phase_scale;
         default:     sel_scale = '0;
      endcase
      corr_diff = corr.corr_in1 - corr.corr_in2;
      corr_prod = corr_diff * $signed({1'b0, sel_scale});
      corr_sum = (corr_prod >>> FRAC_SHIFT) + corr.err_in;
      corr.corrected = count_t'(corr_sum);
   end

   ////////////////////////////////////////////////////////////////////////////
   // next code, clamped to 0 .. CODE_MAX

   always_comb begin
      case (code.base_sel)
         BASE_INIT: base = init_code;
         BASE_LOCK: base = lock_reg;
         default:   base = code_reg;
      endcase
      code_prod = code.update * gain_n;
      code_sum = (code_prod >>> FRAC_SHIFT) + $signed({13'b0, base});
      if (code_sum < 0) begin
         code_next = '0;
      end else if (code_sum > $signed({13'b0, CODE_MAX})) begin
         code_next = CODE_MAX;
      end else begin
         code_next = code_sum[13:0];
      end
   end

   always_ff @(posedge dco_change_edge) begin
      if (!reset2) begin
         code_reg <= init_code;
         lock_reg <= init_code;   // cold start hands over init code
         code.update_old <= '0;
      end else begin
         code_reg <= code_next;
         code.update_old <= code.update;
         if (code.store_lock) lock_reg <= code_reg;
      end
   end

   assign dco_code = code_reg[13:1];
   assign locked_code = lock_reg[13:1];

endmodule

// File: design/cycle_correction.sv
`timescale 1ns/10ps

module cycle_correction import dpll_lock_pkg::*; (
   input  logic       dco_change_edge,
   input  logic       reset2,
   input  cyc_t       freq_counter,
   input  logic [2:0] edge_select,
   input  cyc_t       divider,
   output cyc_t       cycle_passed,
   output recip_t     freq_scale,
   output recip_t     phase_scale
);

   cyc_t        freq_d1;
   cyc_t        freq_d2;
   cyc_t        cycles_left;
   recip_t      recip;        // 1/cycles_left, 1.11
   logic [18:0] fs_full;
   logic [18:0] ps_full;

   always_ff @(posedge dco_change_edge) begin
      if (!reset2) begin
         freq_d1 <= '0;
         freq_d2 <= '0;
      end else begin
         freq_d1 <= freq_counter;
         freq_d2 <= freq_d1;
      end
   end

   // dco cycles gone by when the new code reaches the oscillator
   assign cycle_passed = freq_d2 + cyc_t'(EDGE_DELAY_BASE) + cyc_t'(edge_select);
   assign cycles_left = divider - cycle_passed;

   ////////////////////////////////////////////////////////////////////////////
   // reciprocal table, rounded 2048/n

   always_comb begin
      recip = '0;   // outside the table
      for (int n = RECIP_MIN; n <= RECIP_MAX; n++) begin
         if (cycles_left == cyc_t'(n)) begin
            recip = recip_t'((4096 + n) / (2 * n));
         end
      end
   end

   // passed/left and divider/left, both brought to 3.9
   assign fs_full = recip * cycle_passed;
   assign ps_full = recip * divider;

   always_comb begin
      if (|fs_full[18:14]) begin
         freq_scale = '1;   // saturate
      end else begin
         freq_scale = fs_full[13:2];
      end
      if (|ps_full[18:14]) begin
         phase_scale = '1;
      end else begin
         phase_scale = ps_full[13:2];
      end
   end

endmodule

// File: design/dpll_lock_ctrl.sv
`timescale 1ns/10ps

module dpll_lock_ctrl import dpll_lock_pkg::*; (
   input  logic        dco_change_edge,
   input  logic        reset2,
   input  tdc_t        tdc_mag,
   input  logic        early,
   input  cyc_t        freq_counter,
   input  logic [2:0]  edge_select,
   input  cyc_t        divider,
   input  gain_t       gain,
   input  code_t       init_code,
   input  count_t      count_high_limit,
   input  count_t      count_low_limit,
   input  count_t      force_increment,
   input  count_t      force_decrement,
   input  count_t      freq_tol_neg,
   input  count_t      freq_tol_pos,
   input  count_t      phase_tol_neg,
   input  count_t      phase_tol_pos,
   input  logic        cold_start_traditional,
   input  logic        computational_start,
   input  logic        resnap_ack,
   output logic        resnap_req,
   output lock_state_t status,
   output logic        freq_locked,
   output logic        lowbw,
   output out_code_t   dco_code,
   output out_code_t   locked_code
);

   count_t count;
   count_t count_old;
   count_t period_change;
   cyc_t   cycle_passed;
   recip_t freq_scale;
   recip_t phase_scale;

   corr_if corr_bus ();
   code_if code_bus ();

   error_sample u_error_sample (
      .dco_change_edge, .reset2, .tdc_mag, .early,
      .count, .count_old, .period_change
   );

   cycle_correction u_cycle_correction (
      .dco_change_edge, .reset2, .freq_counter, .edge_select, .divider,
      .cycle_passed, .freq_scale, .phase_scale
   );

   lock_fsm u_lock_fsm (
      .dco_change_edge, .reset2,
      .corr (corr_bus.fsm),
      .code (code_bus.fsm),
      .count, .count_old, .period_change,
      .cycle_passed, .divider, .freq_scale,
      .cold_start_traditional, .computational_start,
      .count_high_limit, .count_low_limit,
      .force_increment, .force_decrement,
      .freq_tol_neg, .freq_tol_pos, .phase_tol_neg, .phase_tol_pos,
      .resnap_ack, .resnap_req, .status, .freq_locked, .lowbw
   );

   code_accum u_code_accum (
      .dco_change_edge, .reset2,
      .corr (corr_bus.accum),
      .code (code_bus.accum),
      .gain, .divider, .init_code, .freq_scale, .phase_scale,
      .dco_code, .locked_code
   );

endmodule

// File: design/dpll_lock_if.sv
`timescale 1ns/10ps

// error correction request from the fsm, answered by the accumulator
interface corr_if import dpll_lock_pkg::*; ();

   count_t corr_in1;
   count_t corr_in2;
   sel_t   scale_sel;
   count_t err_in;
   count_t corrected;   // err_in + (in1 - in2) * scale

   modport fsm (
      output corr_in1,
      output corr_in2,
      output scale_sel,
      output err_in,
      input  corrected
   );

   modport accum (
      input  corr_in1,
      input  corr_in2,
      input  scale_sel,
      input  err_in,
      output corrected
   );

endinterface

// code update control
interface code_if import dpll_lock_pkg::*; ();

   count_t update;
   logic   gain_en;
   sel_t   base_sel;
   logic   store_lock;   // capture code at frequency lock
   count_t update_old;

   modport fsm (
      output update,
      output gain_en,
      output base_sel,
      output store_lock,
      input  update_old
   );

   modport accum (
      input  update,
      input  gain_en,
      input  base_sel,
      input  store_lock,
      output update_old
   );

endinterface

// File: design/dpll_lock_pkg.sv
package dpll_lock_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // fixed-point types

   typedef logic signed [13:0] count_t;  // phase count, period change
   typedef logic [12:0] tdc_t;           // tdc magnitude
   typedef logic [13:0] code_t;          // dco code, 9.5
   typedef logic [12:0] out_code_t;      // code without its lsb
   typedef logic [6:0] cyc_t;            // dco cycle count or divider
   typedef logic [11:0] recip_t;         // 1/n in 1.11, scales in 3.9
   typedef logic [7:0] gain_t;           // loop gain, 6.2
   typedef logic signed [11:0] gainn_t;  // gain times N
   typedef logic [1:0] sel_t;            // scale and base selects

   typedef enum logic [4:0] {
      st_start,
      st_wait_init0,
      st_resnap_initial,
      st_wait_after_resnap,
      st_wait_init1,
      st_wait_init2,
      st_freq_first,
      st_freq_second,
      st_freq,
      st_check_effect,
      st_resnap,
      st_phase_wait,
      st_phase_first,
      st_phase,
      st_phase_locked1,
      st_phase_locked,
      st_resnap_wrong,
      st_wait_wrong
   } lock_state_t;

   ////////////////////////////////////////////////////////////////////////////
   // limits and constants

   localparam code_t CODE_MAX = 14'd9600;       // 300.0 in 9.5
   localparam int EDGE_DELAY_BASE = 3;          // dco edges before the code lands
   localparam int RECIP_MIN = 4;
   localparam int RECIP_MAX = 45;
   localparam int FRAC_SHIFT = 9;
   localparam int DIV_MARGIN = 2;
   localparam recip_t SCALE_LIMIT = 12'd768;    // 1.5 in 3.9

   // correction scale select
   localparam sel_t SCALE_NONE = 2'd0;
   localparam sel_t SCALE_FREQ = 2'd1;
   localparam sel_t SCALE_PHASE = 2'd2;

   // code base select
   localparam sel_t BASE_INIT = 2'd0;
   localparam sel_t BASE_RUN = 2'd1;
   localparam sel_t BASE_LOCK = 2'd2;

endpackage

// File: design/error_sample.sv
`timescale 1ns/10ps

module error_sample import dpll_lock_pkg::*; (
   input  logic   dco_change_edge,
   input  logic   reset2,
   input  tdc_t   tdc_mag,
   input  logic   early,
   output count_t count,
   output count_t count_old,
   output count_t period_change
);

   count_t count_signed;

   // early edge means positive phase error
   always_comb begin
      if (early) begin
         count_signed = count_t'({1'b0, tdc_mag});
      end else begin
         count_signed = -count_t'({1'b0, tdc_mag});
      end
   end

   always_ff @(posedge dco_change_edge) begin
      if (!reset2) begin
         count <= '0;
         count_old <= '0;
      end else begin
         count <= count_signed;
         count_old <= count;   // one sample back
      end
   end

   // phase moved this much over one reference period
   assign period_change = count - count_old;

endmodule

// File: design/lock_fsm.sv
`timescale 1ns/10ps

module lock_fsm import dpll_lock_pkg::*; (
   input  logic        dco_change_edge,
   input  logic        reset2,
   corr_if.fsm         corr,
   code_if.fsm         code,
   input  count_t      count,
   input  count_t      count_old,
   input  count_t      period_change,
   input  cyc_t        cycle_passed,
   input  cyc_t        divider,
   input  recip_t      freq_scale,
   input  logic        cold_start_traditional,
   input  logic        computational_start,
   input  count_t      count_high_limit,
   input  count_t      count_low_limit,
   input  count_t      force_increment,
   input  count_t      force_decrement,
   input  count_t      freq_tol_neg,
   input  count_t      freq_tol_pos,
   input  count_t      phase_tol_neg,
   input  count_t      phase_tol_pos,
   input  logic        resnap_ack,
   output logic        resnap_req,
   output lock_state_t status,
   output logic        freq_locked,
   output logic        lowbw
);

   lock_state_t state_n;
   logic        ack_seen;     // ack came back high in this resnap
   logic        ack_seen_n;
   logic        req_n;
   logic        resnap_n;     // next state is a resnap state
   logic        limit_hit;
   logic        late_edge;
   logic        freq_tol_ok;
   logic        phase_tol_ok;

   assign limit_hit = (count >= count_high_limit) || (count <= count_low_limit);
   assign late_edge = cycle_passed >= cyc_t'(divider - cyc_t'(DIV_MARGIN));
   assign freq_tol_ok = (corr.corrected >= freq_tol_neg) && (corr.corrected <= freq_tol_pos);
   assign phase_tol_ok = (count > phase_tol_neg) && (count < phase_tol_pos);

   ////////////////////////////////////////////////////////////////////////////
   // correction inputs, decoded from the state only

   always_comb begin
      corr.corr_in1 = '0;
      corr.corr_in2 = '0;
      corr.err_in = '0;
      corr.scale_sel = SCALE_NONE;
      case (status)
         st_freq_first, st_check_effect: begin
            corr.err_in = period_change;   // plain period change
         end
         st_freq_second, st_freq: begin
            corr.corr_in1 = period_change;
            corr.corr_in2 = code.update_old;
            corr.err_in = period_change;
            corr.scale_sel = SCALE_FREQ;
         end
         st_phase_first, st_phase: begin
            corr.corr_in1 = count;
            corr.scale_sel = SCALE_PHASE;
         end
         default: ;
      endcase
   end

   ////////////////////////////////////////////////////////////////////////////
   // next state and update

   always_comb begin
      state_n = status;
      code.update = '0;
      code.gain_en = 1'b0;
      code.base_sel = BASE_RUN;
      code.store_lock = 1'b0;
      case (status)
         st_start: begin
            code.base_sel = BASE_INIT;
            state_n = st_wait_init0;
         end
         st_wait_init0: begin
            code.base_sel = BASE_INIT;
            state_n = st_resnap_initial;
         end
         st_resnap_initial: begin
            code.base_sel = BASE_INIT;
            if (ack_seen && !resnap_ack) state_n = st_wait_after_resnap;
         end
         st_wait_after_resnap: begin
            code.base_sel = BASE_INIT;
            state_n = st_wait_init2;
         end
         st_wait_init1: begin
            code.base_sel = BASE_INIT;
            state_n = st_wait_init2;
         end
         st_wait_init2: begin
            code.base_sel = BASE_INIT;
            state_n = st_freq_first;
         end
         st_freq_first: begin
            code.gain_en = 1'b1;
            if (count >= count_high_limit) begin
               code.update = force_increment;   // tdc ran out of range
               state_n = st_resnap_wrong;
            end else if (count <= count_low_limit) begin
               code.update = force_decrement;
               state_n = st_resnap_wrong;
            end else if (freq_tol_ok) begin
               state_n = st_check_effect;
            end else begin
               code.update = corr.corrected;
               state_n = st_freq_second;
            end
         end
         st_freq_second, st_freq: begin
            code.gain_en = 1'b1;
            if (limit_hit || late_edge ||
                (status == st_freq && freq_scale >= SCALE_LIMIT)) begin
               state_n = st_resnap_wrong;   // estimate no longer trusted
            end else if (freq_tol_ok) begin
               state_n = st_check_effect;
            end else begin
               code.update = corr.corrected;
               state_n = st_freq;
            end
         end
         st_check_effect: begin
            if (freq_tol_ok) begin
               code.store_lock = 1'b1;
               state_n = st_resnap;
            end else begin
               state_n = st_freq_first;
            end
         end
         st_resnap: begin
            if (ack_seen && !resnap_ack) state_n = st_phase_wait;
         end
         st_phase_wait: begin
            code.base_sel = BASE_LOCK;
            state_n = st_phase_first;
         end
         st_phase_first, st_phase: begin
            code.base_sel = BASE_LOCK;   // offset from the lock code
            code.gain_en = 1'b1;
            if (phase_tol_ok) begin
               state_n = st_phase_locked1;
            end else begin
               state_n = st_phase;
               if (status == st_phase && (count[13] ^ count_old[13])) begin
                  code.update = corr.corrected >>> 1;   // crossed zero, back off
               end else begin
                  code.update = corr.corrected;
               end
            end
         end
         st_phase_locked1: begin
            code.base_sel = BASE_LOCK;
            state_n = st_phase_locked;
         end
         st_phase_locked: begin
            code.base_sel = BASE_LOCK;   // hand over the lock code
            if (computational_start) state_n = st_wait_init1;
         end
         st_resnap_wrong: begin
            if (ack_seen && !resnap_ack) state_n = st_wait_wrong;
         end
         st_wait_wrong: begin
            state_n = st_freq_first;
         end
         default: state_n = st_start;
      endcase
   end

   ////////////////////////////////////////////////////////////////////////////
   // four-phase resnap handshake

   assign resnap_n = state_n inside {st_resnap_initial, st_resnap, st_resnap_wrong};
   assign ack_seen_n = resnap_n && (ack_seen || (resnap_req && resnap_ack));
   assign req_n = resnap_n && !ack_seen_n && (resnap_req || !resnap_ack);   // no rise on ack high

   always_ff @(posedge dco_change_edge) begin
      if (!reset2) begin
         status <= cold_start_traditional ? st_phase_locked : st_start;
         resnap_req <= 1'b0;
         ack_seen <= 1'b0;
      end else begin
         status <= state_n;
         resnap_req <= req_n;
         ack_seen <= ack_seen_n;
      end
   end

   assign freq_locked = status inside {st_resnap, st_phase_wait, st_phase_first, st_phase,
                                       st_phase_locked1, st_phase_locked};
   assign lowbw = (status == st_phase_locked);

endmodule

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module dpll_lock_tb -f all.f -o sim_dpll_lock

out="$(./obj_dir/sim_dpll_lock)"
echo "$out"

if grep -Fqx ">>> PASS" <<< "$out"; then
   exit 0
else
   exit 1
fi

// File: sim/dpll_lock_tb.sv
`timescale 1ns/10ps

module dpll_lock_tb import dpll_lock_pkg::*; ();

   localparam int N_ROWS = 8;
   localparam int CYCLE_LIMIT = N_ROWS * 40 + 5;

   logic        clk;
   logic        reset2;
   tdc_t        tdc_mag;
   logic        early;
   cyc_t        freq_counter;
   logic [2:0]  edge_select;
   cyc_t        divider;
   gain_t       gain;
   code_t       init_code;
   count_t      count_high_limit;
   count_t      count_low_limit;
   count_t      force_increment;
   count_t      force_decrement;
   count_t      freq_tol_neg;
   count_t      freq_tol_pos;
   count_t      phase_tol_neg;
   count_t      phase_tol_pos;
   logic        cold_start_traditional;
   logic        computational_start;
   logic        resnap_ack;
   logic        resnap_req;
   lock_state_t status;
   logic        freq_locked;
   logic        lowbw;
   out_code_t   dco_code;
   out_code_t   locked_code;

   int          row_id;
   lock_state_t cur_trig;
   lock_state_t cur_exp;
   logic [1:0]  cur_rule;
   int          done_count;
   int          err_count;
   logic        finished;
   int          cycles;
   int          pending;
   logic [16:0] lfsr;

   ////////////////////////////////////////////////////////////////////////////
   // stimulus table
   // code rule 0 keeps the code, 1 forces it up, 2 forces it down

   lock_state_t row_trig [N_ROWS] = '{st_wait_after_resnap, st_resnap_wrong, st_resnap_wrong,
      st_resnap, st_phase_locked1, st_phase_locked, st_wait_init1, st_resnap_wrong};
   tdc_t        row_tdc [N_ROWS] = '{1200, 1200, 0, 3, 3, 3, 1200, 1200};
   logic        row_early [N_ROWS] = '{1, 0, 1, 1, 1, 1, 1, 0};
   cyc_t        row_freq [N_ROWS] = '{5, 5, 2, 2, 2, 2, 5, 5};
   logic        row_comp [N_ROWS] = '{0, 0, 0, 0, 0, 1, 0, 0};
   count_t      row_inc [N_ROWS] = '{1280, 1280, 1280, 1280, 1280, 1280, 8000, 8000};
   count_t      row_dec [N_ROWS] = '{-1280, -1280, -1280, -1280, -1280, -1280, -8000, -8000};
   lock_state_t row_exp [N_ROWS] = '{st_resnap_wrong, st_resnap_wrong, st_resnap,
      st_phase_locked1, st_phase_locked, st_wait_init1, st_resnap_wrong, st_resnap_wrong};
   logic [1:0]  row_rule [N_ROWS] = '{1, 2, 0, 0, 0, 0, 1, 2};

   tb_clock_gen u_clock_gen (.dco_change_edge(clk), .reset2);

   dpll_lock_ctrl DUT (
      .dco_change_edge(clk), .reset2, .tdc_mag, .early, .freq_counter, .edge_select,
      .divider, .gain, .init_code, .count_high_limit, .count_low_limit,
      .force_increment, .force_decrement, .freq_tol_neg, .freq_tol_pos,
      .phase_tol_neg, .phase_tol_pos, .cold_start_traditional, .computational_start,
      .resnap_ack, .resnap_req, .status, .freq_locked, .lowbw, .dco_code, .locked_code
   );

   lock_checker #(.N_ROWS(N_ROWS)) u_checker (
      .dco_change_edge(clk), .reset2, .status, .resnap_req, .resnap_ack, .freq_locked,
      .lowbw, .dco_code, .locked_code, .init_code, .gain, .divider, .force_increment,
      .force_decrement, .row_id, .row_trig(cur_trig), .row_exp(cur_exp),
      .row_rule(cur_rule), .done_count, .err_count, .finished
   );

   // x^17 + x^14 + 1
   function automatic logic [16:0] lfsr_next(input logic [16:0] s);
      return {s[15:0], s[16] ^ s[13]};
   endfunction

   task automatic draw_delay(output int d);
      d = 1;
      for (int b = 0; b < 2; b++) begin
         lfsr = lfsr_next(lfsr);   // one step per bit
         d = d + (int'(lfsr[0]) << b);
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // resnap responder
   // ack follows req after 1 .. 4 cycles

   always @(negedge clk) begin
      if (!reset2) begin
         resnap_ack <= 1'b0;
         pending = 0;
      end else if (resnap_req != resnap_ack) begin
         if (pending == 0) draw_delay(pending);
         pending = pending - 1;
         if (pending == 0) resnap_ack <= resnap_req;
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles > CYCLE_LIMIT) begin
         $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
         $display(">>> FAIL");
         $finish;
      end
   end

   initial begin
      cycles = 0;
      pending = 0;
      lfsr = 17'd73316;
      row_id = 0;
      cur_trig = st_start;
      cur_exp = st_start;
      cur_rule = 2'd0;
      tdc_mag = '0;
      early = 1'b1;
      freq_counter = '0;
      edge_select = '0;
      divider = 7'd40;
      gain = 8'd200;            // 50.0
      init_code = 14'd3200;     // 100.0
      count_high_limit = 14'sd1000;
      count_low_limit = -14'sd1000;
      force_increment = 14'sd1280;
      force_decrement = -14'sd1280;
      freq_tol_neg = -14'sd4;
      freq_tol_pos = 14'sd4;
      phase_tol_neg = -14'sd8;
      phase_tol_pos = 14'sd8;
      cold_start_traditional = 1'b1;
      computational_start = 1'b0;
      resnap_ack = 1'b0;

      repeat (3) @(negedge clk);
      cold_start_traditional = 1'b0;

      for (int i = 0; i < N_ROWS; i++) begin
         while (status != row_trig[i]) @(negedge clk);
         tdc_mag = row_tdc[i];
         early = row_early[i];
         freq_counter = row_freq[i];
         computational_start = row_comp[i];
         force_increment = row_inc[i];
         force_decrement = row_dec[i];
         cur_trig = row_trig[i];
         cur_exp = row_exp[i];
         cur_rule = row_rule[i];
         row_id = i + 1;
         wait (done_count == i + 1);
      end

      wait (finished);
      if (err_count == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

// File: sim/lock_checker.sv
`timescale 1ns/10ps

module lock_checker import dpll_lock_pkg::*; #(
   parameter int N_ROWS = 1
) (
   input  logic        dco_change_edge,
   input  logic        reset2,
   input  lock_state_t status,
   input  logic        resnap_req,
   input  logic        resnap_ack,
   input  logic        freq_locked,
   input  logic        lowbw,
   input  out_code_t   dco_code,
   input  out_code_t   locked_code,
   input  code_t       init_code,
   input  gain_t       gain,
   input  cyc_t        divider,
   input  count_t      force_increment,
   input  count_t      force_decrement,
   input  int          row_id,
   input  lock_state_t row_trig,
   input  lock_state_t row_exp,
   input  logic [1:0]  row_rule,
   output int          done_count,
   output int          err_count,
   output logic        finished
);

   int          row_errs;
   int          mon_errs;
   int          errs_before;
   int          passed;
   int          ref_code;    // expected 9.5 code
   logic        req_prev;
   lock_state_t state_prev;

   assign err_count = row_errs + mon_errs;

   // base plus update times gain times N within 0 .. CODE_MAX
   function automatic int step_code(input int base, input int upd);
      int gainn;
      int sum;
      gainn = (int'(gain) * int'(divider)) >> 2;
      sum = base + ((upd * gainn) >>> FRAC_SHIFT);
      if (sum < 0) sum = 0;
      if (sum > int'(CODE_MAX)) sum = int'(CODE_MAX);
      return sum;
   endfunction

   task automatic report(input string name);
      if (row_errs == errs_before) begin
         $display("test %0s: ok", name);
         passed++;
      end else begin
         $display("test %0s: failed", name);
      end
   endtask

   initial begin
      row_errs = 0;
      passed = 0;
      done_count = 0;
      finished = 1'b0;

      //////////////////////////////////////////////////////////////////////////
      // cold start first and then plain reset values
      repeat (3) @(negedge dco_change_edge);
      errs_before = row_errs;
      if (status != st_phase_locked || !lowbw) begin
         $display("ERROR at %0t: cold start gave %0s lowbw %b", $time, status.name(), lowbw);
         row_errs++;
      end
      report("cold_start");

      @(posedge reset2);
      errs_before = row_errs;
      if (status != st_start || resnap_req || freq_locked || lowbw ||
          dco_code != init_code[13:1]) begin
         $display("ERROR at %0t: reset values wrong, %0s req %b fl %b lowbw %b code %0d",
                  $time, status.name(), resnap_req, freq_locked, lowbw, dco_code);
         row_errs++;
      end
      report("reset");
      ref_code = int'(init_code);

      for (int r = 0; r < N_ROWS; r++) begin
         wait (row_id == r + 1);
         errs_before = row_errs;
         @(negedge dco_change_edge);
         while (status == row_trig) @(negedge dco_change_edge);
         while (status != row_exp) @(negedge dco_change_edge);
         if (row_rule == 2'd1) ref_code = step_code(ref_code, int'(force_increment));
         if (row_rule == 2'd2) ref_code = step_code(ref_code, int'(force_decrement));
         if (dco_code != out_code_t'(ref_code >> 1)) begin
            $display("ERROR at %0t: dco_code %0d, expected %0d", $time, dco_code,
                     ref_code >> 1);
            row_errs++;
         end
         if (row_exp == st_resnap &&
             (!freq_locked || locked_code != out_code_t'(ref_code >> 1))) begin
            $display("ERROR at %0t: freq lock fl %b locked_code %0d, expected %0d", $time,
                     freq_locked, locked_code, ref_code >> 1);
            row_errs++;
         end
         if (row_exp == st_resnap_wrong && freq_locked) begin
            $display("ERROR at %0t: freq_locked high before frequency lock", $time);
            row_errs++;
         end
         if (row_exp == st_phase_locked && !lowbw) begin
            $display("ERROR at %0t: lowbw low in phase lock", $time);
            row_errs++;
         end
         report($sformatf("row%0d_%0s", r, row_exp.name()));
         done_count = r + 1;
      end

      $display("tests passed %0d of %0d, errors %0d", passed, N_ROWS + 2, err_count);
      finished = 1'b1;
   end

   ////////////////////////////////////////////////////////////////////////////
   // handshake, resnap exits and clamp are watched every cycle

   initial begin
      mon_errs = 0;
      req_prev = 1'b0;
      state_prev = st_start;
   end

   always @(negedge dco_change_edge) begin
      if (reset2) begin
         if (resnap_req && !req_prev && resnap_ack) begin
            $display("ERROR at %0t: resnap_req rose with ack high", $time);
            mon_errs++;
         end
         if (!resnap_req && req_prev && !resnap_ack) begin
            $display("ERROR at %0t: resnap_req fell before ack", $time);
            mon_errs++;
         end
         if (status != state_prev &&
             ((state_prev == st_resnap_initial && status != st_wait_after_resnap) ||
              (state_prev == st_resnap && status != st_phase_wait) ||
              (state_prev == st_resnap_wrong && status != st_wait_wrong))) begin
            $display("ERROR at %0t: %0s left to %0s", $time, state_prev.name(), status.name());
            mon_errs++;
         end
         if (dco_code > CODE_MAX[13:1]) begin
            $display("ERROR at %0t: dco_code %0d above clamp", $time, dco_code);
            mon_errs++;
         end
      end
      req_prev = resnap_req;
      state_prev = status;
   end

endmodule

// File: sim/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen (
   output logic dco_change_edge,
   output logic reset2
);

   initial begin
      dco_change_edge = 1'b0;
      forever #2 dco_change_edge = ~dco_change_edge;   // 4 ns period
   end

   // held low for five rising edges, released on a falling edge
   initial begin
      reset2 = 1'b0;
      repeat (5) @(posedge dco_change_edge);
      @(negedge dco_change_edge);
      reset2 = 1'b1;
   end

endmodule
